/* ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

   // ALU operation picked by decode
   typedef enum logic [1:0] {
      // A plus B
      ALU_ADD = 2'b00,
      // A minus B
      ALU_SUB = 2'b01,
      ALU_XOR = 2'b10,
      ALU_AND = 2'b11
   } alu_op_e;

   // Source of the value written back to the register file
   typedef enum logic [1:0] {
      // ALU result
      WB_ALU = 2'b00,
      // Data memory read
      WB_MEM = 2'b01,
      // Return address for JAL
      WB_PC  = 2'b10
   } wb_sel_e;

endpackage

`default_nettype wire

/* decode.sv */
`default_nettype none
`timescale 1ns/1ps

`include "proc_cfg.svh"

module decode (
   input  wire logic                             clk,
   input  wire logic                             reset,
   input  wire isa_pkg::instr_u                  instruction,
   input  wire logic [`PROC_WIDTH-1:0]          inc_pc,
   input  wire logic                             issue,
   input  wire logic [`PROC_WIDTH-1:0]          wb_data,
   output logic      [`PROC_WIDTH-1:0]          operand_a,
   output logic      [`PROC_WIDTH-1:0]          operand_b,
   output logic      [`PROC_WIDTH-1:0]          immediate,
   output logic                                  alu_src,
   output ctrl_pkg::alu_op_e                     alu_op,
   output logic      [`PROC_WIDTH-1:0]          store_data,
   output logic                                  mem_write,
   output ctrl_pkg::wb_sel_e                     wb_sel,
   output logic                                  wb_en,
   output logic      [$clog2(`PROC_REGS)-1:0]   wb_reg,
   output logic                                  take_target,
   output logic      [`PROC_WIDTH-1:0]          target,
   output logic                                  halt_req,
   output logic                                  illegal
);

   logic [`PROC_WIDTH-1:0] rs_val;
   logic [`PROC_WIDTH-1:0] rt_val;
   logic [`PROC_WIDTH-1:0] sext_imm5;
   logic [`PROC_WIDTH-1:0] sext_disp11;
   logic                   zext;
   logic                   reg_write;
   logic                   is_store;

   // Port 2 reads bits 7..5 which hold rt in R format and rd for ST
   rf rf_blk (
      .clk         (clk),
      .reset       (reset),
      .read_reg_1  (instruction.r.rs),
      .read_reg_2  (instruction.r.rt),
      .write_en    (wb_en),
      .write_reg   (wb_reg),
      .write_data  (wb_data),
      .read_data_1 (rs_val),
      .read_data_2 (rt_val)
   );

   assign sext_imm5   = {{(`PROC_WIDTH-5){instruction.i.imm5[4]}}, instruction.i.imm5};
   assign sext_disp11 = {{(`PROC_WIDTH-11){instruction.j.disp11[10]}}, instruction.j.disp11};

   // Logic ops take the immediate unsigned
   assign immediate = zext ? {{(`PROC_WIDTH-5){1'b0}}, instruction.i.imm5} : sext_imm5;

   assign operand_a  = rs_val;
   assign operand_b  = rt_val;
   assign store_data = rt_val;

   // Nothing changes state unless the instruction issues
   assign wb_en     = issue && reg_write;
   assign mem_write = issue && is_store;

   always_comb begin
      alu_src     = 1'b0;
      alu_op      = ctrl_pkg::ALU_ADD;
      wb_sel      = ctrl_pkg::WB_ALU;
      zext        = 1'b0;
      reg_write   = 1'b0;
      is_store    = 1'b0;
      wb_reg      = instruction.i.rd;
      take_target = 1'b0;
      target      = inc_pc + sext_imm5;
      halt_req    = 1'b0;
      illegal     = 1'b0;
      case (instruction.r.opcode)
         isa_pkg::OP_RTYPE: begin
            reg_write = 1'b1;
            wb_reg    = instruction.r.rd;
            case (instruction.r.func)
               isa_pkg::FN_ADD: alu_op = ctrl_pkg::ALU_ADD;
               isa_pkg::FN_SUB: alu_op = ctrl_pkg::ALU_SUB;
               isa_pkg::FN_XOR: alu_op = ctrl_pkg::ALU_XOR;
               isa_pkg::FN_AND: alu_op = ctrl_pkg::ALU_AND;
            endcase
         end
         isa_pkg::OP_ADDI: begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         isa_pkg::OP_SUBI: begin
            alu_src   = 1'b1;
            alu_op    = ctrl_pkg::ALU_SUB;
            reg_write = 1'b1;
         end
         isa_pkg::OP_XORI: begin
            alu_src   = 1'b1;
            alu_op    = ctrl_pkg::ALU_XOR;
            zext      = 1'b1;
            reg_write = 1'b1;
         end
         isa_pkg::OP_ANDI: begin
            alu_src   = 1'b1;
            alu_op    = ctrl_pkg::ALU_AND;
            zext      = 1'b1;
            reg_write = 1'b1;
         end
         // Address is rs plus signed offset for both memory ops
         isa_pkg::OP_LD: begin
            alu_src   = 1'b1;
            wb_sel    = ctrl_pkg::WB_MEM;
            reg_write = 1'b1;
         end
         isa_pkg::OP_ST: begin
            alu_src  = 1'b1;
            is_store = 1'b1;
         end
         // Branches test rs against zero
         isa_pkg::OP_BEQZ: take_target = (rs_val == '0);
         isa_pkg::OP_BNEZ: take_target = (rs_val != '0);
         isa_pkg::OP_J: begin
            take_target = 1'b1;
            target      = inc_pc + sext_disp11;
         end
         // Link register is r7
         isa_pkg::OP_JAL: begin
            take_target = 1'b1;
            target      = inc_pc + sext_disp11;
            reg_write   = 1'b1;
            wb_reg      = '1;
            wb_sel      = ctrl_pkg::WB_PC;
         end
         isa_pkg::OP_JR: begin
            take_target = 1'b1;
            target      = rs_val + sext_imm5;
         end
         isa_pkg::OP_NOP: ;
         isa_pkg::OP_HALT: halt_req = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* execute.sv */
`default_nettype none
`timescale 1ns/1ps

`include "proc_cfg.svh"

module execute (
   input  wire logic [`PROC_WIDTH-1:0] operand_a,
   input  wire logic [`PROC_WIDTH-1:0] operand_b,
   input  wire logic [`PROC_WIDTH-1:0] immediate,
   input  wire logic                    alu_src,
   input  wire ctrl_pkg::alu_op_e       alu_op,
   output logic      [`PROC_WIDTH-1:0] alu_out
);

   logic [`PROC_WIDTH-1:0] b;

   // Immediate forms replace the rt operand
   assign b = alu_src ? immediate : operand_b;

   always_comb begin
      alu_out = operand_a + b;
      case (alu_op)
         ctrl_pkg::ALU_SUB: alu_out = operand_a - b;
         ctrl_pkg::ALU_XOR: alu_out = operand_a ^ b;
         ctrl_pkg::ALU_AND: alu_out = operand_a & b;
         // ALU_ADD keeps the sum
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* fetch.sv */
`default_nettype none
`timescale 1ns/1ps

`include "proc_cfg.svh"

module fetch (
   input  wire logic                                 clk,
   input  wire logic                                 reset,
   input  wire logic                                 load_en,
   input  wire logic [$clog2(`PROC_IMEM_DEPTH)-1:0] load_addr,
   input  wire logic [`PROC_WIDTH-1:0]              load_data,
   input  wire logic                                 take_target,
   input  wire logic [`PROC_WIDTH-1:0]              target,
   input  wire logic                                 halt_req,
   input  wire logic                                 illegal,
   output isa_pkg::instr_u                           instruction,
   output logic      [`PROC_WIDTH-1:0]              inc_pc,
   output logic                                      issue,
   output logic                                      halted,
   output logic                                      err
);

   logic [`PROC_WIDTH-1:0] pc;
   logic [`PROC_WIDTH-1:0] imem [0:`PROC_IMEM_DEPTH-1];

   // Load port, written only by the testbench
   always_ff @(posedge clk) begin
      if (load_en) begin
         imem[load_addr] <= load_data;
      end
   end

   // Asynchronous read, low address bits only
   assign instruction = imem[pc[$clog2(`PROC_IMEM_DEPTH)-1:0]];
   assign inc_pc      = pc + 1'b1;

   // Current instruction completes this cycle
   assign issue = !halted && !load_en;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (issue) begin
         // PC parks on the stopping instruction
         if (halt_req || illegal) begin
            halted <= 1'b1;
         end else begin
            pc <= take_target ? target : inc_pc;
         end
         // Sticky until reset
         if (illegal) begin
            err <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

   // Opcodes live in bits 15..11
   localparam logic [4:0] OP_HALT  = 5'b00000;
   localparam logic [4:0] OP_NOP   = 5'b00001;
   localparam logic [4:0] OP_J     = 5'b00100;
   localparam logic [4:0] OP_JR    = 5'b00101;
   localparam logic [4:0] OP_JAL   = 5'b00110;
   localparam logic [4:0] OP_ADDI  = 5'b01000;
   localparam logic [4:0] OP_SUBI  = 5'b01001;
   localparam logic [4:0] OP_XORI  = 5'b01010;
   localparam logic [4:0] OP_ANDI  = 5'b01011;
   localparam logic [4:0] OP_BEQZ  = 5'b01100;
   localparam logic [4:0] OP_BNEZ  = 5'b01101;
   localparam logic [4:0] OP_ST    = 5'b10000;
   localparam logic [4:0] OP_LD    = 5'b10001;
   localparam logic [4:0] OP_RTYPE = 5'b11011;

   // Function field of RTYPE
   localparam logic [1:0] FN_ADD = 2'b00;
   localparam logic [1:0] FN_SUB = 2'b01;
   localparam logic [1:0] FN_XOR = 2'b10;
   localparam logic [1:0] FN_AND = 2'b11;

   // Register-register format
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } r_fmt_t;

   // Immediate format, rd sits where rt does in R format
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm5;
   } i_fmt_t;

   // Jump format
   typedef struct packed {
      logic [4:0]  opcode;
      logic [10:0] disp11;
   } j_fmt_t;

   // One instruction word, three ways to read it
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } instr_u;

endpackage

`default_nettype wire

/* memory.sv */
`default_nettype none
`timescale 1ns/1ps

`include "proc_cfg.svh"

module memory (
   input  wire logic                    clk,
   input  wire logic [`PROC_WIDTH-1:0] alu_out,
   input  wire logic [`PROC_WIDTH-1:0] store_data,
   input  wire logic                    mem_write,
   input  wire ctrl_pkg::wb_sel_e       wb_sel,
   input  wire logic [`PROC_WIDTH-1:0] inc_pc,
   output logic      [`PROC_WIDTH-1:0] wb_data
);

   logic [`PROC_WIDTH-1:0]              dmem [0:`PROC_DMEM_DEPTH-1];
   logic [$clog2(`PROC_DMEM_DEPTH)-1:0] addr;

   // Word address from the low ALU bits
   assign addr = alu_out[$clog2(`PROC_DMEM_DEPTH)-1:0];

   always_ff @(posedge clk) begin
      if (mem_write) begin
         dmem[addr] <= store_data;
      end
   end

   // Writeback choice, read is combinational
   always_comb begin
      case (wb_sel)
         ctrl_pkg::WB_MEM: wb_data = dmem[addr];
         ctrl_pkg::WB_PC:  wb_data = inc_pc;
         default:          wb_data = alu_out;
      endcase
   end

endmodule

`default_nettype wire

/* proc.f */
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
rf.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc.sv
proc_tb.sv

/* proc.sv */
`default_nettype none
`timescale 1ns/1ps

`include "proc_cfg.svh"

module proc (
   input  wire logic                                 clk,
   input  wire logic                                 reset,
   input  wire logic                                 load_en,
   input  wire logic [$clog2(`PROC_IMEM_DEPTH)-1:0] load_addr,
   input  wire logic [`PROC_WIDTH-1:0]              load_data,
   output logic                                      err,
   output logic                                      halted,
   output logic                                      wb_en,
   output logic      [$clog2(`PROC_REGS)-1:0]       wb_reg,
   output logic      [`PROC_WIDTH-1:0]              wb_value
);

   isa_pkg::instr_u        instruction;
   logic [`PROC_WIDTH-1:0] inc_pc;
   logic                   issue;
   logic                   take_target;
   logic [`PROC_WIDTH-1:0] target;
   logic                   halt_req;
   logic                   illegal;

   logic [`PROC_WIDTH-1:0] operand_a;
   logic [`PROC_WIDTH-1:0] operand_b;
   logic [`PROC_WIDTH-1:0] immediate;
   logic                   alu_src;
   ctrl_pkg::alu_op_e      alu_op;
   logic [`PROC_WIDTH-1:0] alu_out;

   logic [`PROC_WIDTH-1:0] store_data;
   logic                   mem_write;
   ctrl_pkg::wb_sel_e      wb_sel;

   fetch fetch_blk (.clk(clk), .reset(reset), .load_en(load_en), .load_addr(load_addr),
                    .load_data(load_data), .take_target(take_target), .target(target),
                    .halt_req(halt_req), .illegal(illegal), .instruction(instruction),
                    .inc_pc(inc_pc), .issue(issue), .halted(halted), .err(err));

   // Writeback value loops back into the register file
   decode decode_blk (.clk(clk), .reset(reset), .instruction(instruction), .inc_pc(inc_pc),
                      .issue(issue), .wb_data(wb_value), .operand_a(operand_a),
                      .operand_b(operand_b), .immediate(immediate), .alu_src(alu_src),
                      .alu_op(alu_op), .store_data(store_data), .mem_write(mem_write),
                      .wb_sel(wb_sel), .wb_en(wb_en), .wb_reg(wb_reg),
                      .take_target(take_target), .target(target), .halt_req(halt_req),
                      .illegal(illegal));

   execute execute_blk (.operand_a(operand_a), .operand_b(operand_b), .immediate(immediate),
                        .alu_src(alu_src), .alu_op(alu_op), .alu_out(alu_out));

   memory memory_blk (.clk(clk), .alu_out(alu_out), .store_data(store_data),
                      .mem_write(mem_write), .wb_sel(wb_sel), .inc_pc(inc_pc),
                      .wb_data(wb_value));

endmodule

`default_nettype wire

/* proc_cfg.svh */
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Data and instruction word width
`define PROC_WIDTH 16

// Architectural registers, 3-bit index
`define PROC_REGS 8

// Word-addressed memories, low 8 address bits used
`define PROC_IMEM_DEPTH 256
`define PROC_DMEM_DEPTH 256

`endif

/* proc_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "proc_cfg.svh"

module proc_tb;

   // Cycles allowed for a program to reach halt
   localparam int RUN_TIMEOUT = 500;
   // Quiet cycles checked once halted
   localparam int HALT_WINDOW = 20;

   logic                                 clk;
   logic                                 reset;
   logic                                 load_en;
   logic [$clog2(`PROC_IMEM_DEPTH)-1:0] load_addr;
   logic [`PROC_WIDTH-1:0]              load_data;
   logic                                 err;
   logic                                 halted;
   logic                                 wb_en;
   logic [$clog2(`PROC_REGS)-1:0]       wb_reg;
   logic [`PROC_WIDTH-1:0]              wb_value;

   // Current program and its expected writebacks in order
   logic [7:0]             prog_addr [$];
   logic [`PROC_WIDTH-1:0] prog_word [$];
   logic [2:0]             exp_reg [$];
   logic [`PROC_WIDTH-1:0] exp_val [$];
   int                     programs_run;

   proc u_proc (
      .clk       (clk),
      .reset     (reset),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .err       (err),
      .halted    (halted),
      .wb_en     (wb_en),
      .wb_reg    (wb_reg),
      .wb_value  (wb_value)
   );

   // 100 ns clock
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
         stop_run();
      end
   endtask

   // Reset is sampled high at four edges and the caller releases it
   task automatic reset_dut();
      @(posedge clk);
      reset   <= 1'b1;
      load_en <= 1'b0;
      repeat (4) @(posedge clk);
   endtask

   // Reset drops on the same edge the first word goes in, so nothing issues in between
   task automatic load_program();
      reset <= 1'b0;
      for (int i = 0; i < prog_addr.size(); i++) begin
         load_en   <= 1'b1;
         load_addr <= prog_addr[i];
         load_data <= prog_word[i];
         @(posedge clk);
         // Processor is stalled while loading
         check_value(wb_en, 0, "writeback while loading");
      end
      load_en <= 1'b0;
   endtask

   task automatic run_program(input logic exp_err);
      int cycles;
      cycles = 0;
      // Outputs are read at the edge before the DUT registers update
      while (!halted) begin
         if (cycles == RUN_TIMEOUT) begin
            $display("Timeout: processor did not halt within %0d cycles", RUN_TIMEOUT);
            stop_run();
         end
         @(posedge clk);
         cycles++;
         if (wb_en) begin
            check_value(exp_reg.size() != 0, 1, "writeback beyond the expected list");
            check_value(wb_reg, exp_reg.pop_front(), "writeback register");
            check_value(wb_value, exp_val.pop_front(), "writeback value");
         end
      end
      check_value(exp_reg.size(), 0, "writebacks still expected at halt");
      check_value(err, exp_err, "err at halt");
      // Halt is sticky and silent
      for (int i = 0; i < HALT_WINDOW; i++) begin
         @(posedge clk);
         check_value(wb_en, 0, "writeback after halt");
         check_value(halted, 1, "halted stays set");
      end
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      byte         kind;
      logic [31:0] a;
      logic [31:0] b;
      reset        = 1'b1;
      load_en      = 1'b0;
      load_addr    = '0;
      load_data    = '0;
      programs_run = 0;
      fd = $fopen("proc_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open proc_testdata.txt");
         stop_run();
      end
      while (!$feof(fd)) begin
         line = "";
         n    = $fgets(line, fd);
         kind = (n > 0) ? line.getc(0) : "#";
         if (kind == "P") begin
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
            check_value(n, 2, "fields on a program line");
            prog_addr.push_back(a[7:0]);
            prog_word.push_back(b[15:0]);
         end else if (kind == "W") begin
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
            check_value(n, 2, "fields on a writeback line");
            exp_reg.push_back(a[2:0]);
            exp_val.push_back(b[15:0]);
         end else if (kind == "S") begin
            n = $sscanf(line.substr(1, line.len() - 1), "%h", a);
            check_value(n, 1, "fields on a status line");
            // Status line closes a program and starts its run
            reset_dut();
            load_program();
            run_program(a[0]);
            programs_run++;
            $display("Program %0d done at %0d ns", programs_run, $time);
            prog_addr.delete();
            prog_word.delete();
         end else if (kind != "#" && kind != "\n" && kind != "\r" && kind != " ") begin
            $display("Unknown line in test data: %s", line);
            stop_run();
         end
      end
      $fclose(fd);
      if (programs_run == 0) begin
         $display("No program found in test data");
         stop_run();
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* proc_testdata.txt */
# P addr word = program word (hex), W reg value = expected writeback in order (hex)
# S err = run the program, expect halted with this err value
P 00 4025
P 01 405D
P 02 497E
P 03 529F
P 04 5AB5
P 05 D978
P 06 D959
P 07 D972
P 08 DA77
P 09 81C3
P 0A 8B41
P 0B 6001
P 0C 4021
P 0D 6801
P 0E 4361
P 0F 6B02
P 10 4021
P 11 4021
P 12 6301
P 13 3003
P 14 4089
P 15 2003
P 16 4021
P 17 57A3
P 18 2F00
P 19 0000
W 1 0005
W 2 FFFD
W 3 0007
W 4 FFE2
W 5 0015
W 6 000C
W 6 0008
W 4 0002
W 5 0005
W 2 0008
W 3 0008
W 7 0014
W 5 0017
W 4 0009
S 0
# Countdown loop, store and load through a wrapped address, then an illegal opcode
P 00 4022
P 01 0800
P 02 4921
P 03 691E
P 04 405F
P 05 814A
P 06 8A6B
P 07 2002
P 08 40A1
P 09 40A2
P 0A F800
P 0B 4087
P 0C 0000
W 1 0002
W 1 0001
W 1 0000
W 2 FFFF
W 3 FFFF
S 1

/* rf.sv */
`default_nettype none
`timescale 1ns/1ps

`include "proc_cfg.svh"

module rf (
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic [$clog2(`PROC_REGS)-1:0] read_reg_1,
   input  wire logic [$clog2(`PROC_REGS)-1:0] read_reg_2,
   input  wire logic                           write_en,
   input  wire logic [$clog2(`PROC_REGS)-1:0] write_reg,
   input  wire logic [`PROC_WIDTH-1:0]        write_data,
   output logic      [`PROC_WIDTH-1:0]        read_data_1,
   output logic      [`PROC_WIDTH-1:0]        read_data_2
);

   logic [`PROC_WIDTH-1:0] regs [0:`PROC_REGS-1];

   // Write lands at the edge, all registers cleared on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `PROC_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en) begin
         regs[write_reg] <= write_data;
      end
   end

   // No bypass, a read sees the value from before the edge
   assign read_data_1 = regs[read_reg_1];
   assign read_data_2 = regs[read_reg_2];

endmodule

`default_nettype wire
